//--- logic/xbar_cfg_pkg.sv
`default_nettype none

package xbar_cfg_pkg;

  // caller id carried with each request
  localparam int ID_W = 4;

  // slot index, also used as the bank tag
  localparam int TAG_W = 3;
  localparam int SLOTS = 8;

  // bit 4 picks the bank, bits 3..0 the word
  localparam int ADDR_W = 5;

  localparam int DATA_W = 8;

endpackage

`default_nettype wire

//--- logic/xbar_op_pkg.sv
`default_nettype none

package xbar_op_pkg;

  // request opcodes
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // address bit that selects bank 0 or bank 1
  localparam int BANK_SEL_BIT = 4;

endpackage

`default_nettype wire

//--- logic/req_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module req_ingress (
  input  wire                                  clk_i,
  input  wire                                  rst_i,
  input  wire                                  req_valid_i,
  output logic                                 req_ready_o,
  input  wire [xbar_cfg_pkg::ID_W-1:0]         req_id_i,
  input  wire xbar_op_pkg::op_e                req_op_i,
  input  wire [xbar_cfg_pkg::ADDR_W-1:0]       req_addr_i,
  input  wire [xbar_cfg_pkg::DATA_W-1:0]       req_wdata_i,
  input  wire                                  alloc_ready_i,
  input  wire [xbar_cfg_pkg::TAG_W-1:0]        alloc_tag_i,
  input  wire                                  bank0_ready_i,
  input  wire                                  bank1_ready_i,
  output logic                                 alloc_valid_o,
  output logic [xbar_cfg_pkg::ID_W-1:0]        alloc_id_o,
  output logic                                 bank0_valid_o,
  output logic                                 bank1_valid_o,
  output logic [xbar_cfg_pkg::TAG_W-1:0]       bank_tag_o,
  output xbar_op_pkg::op_e                     bank_op_o,
  output logic [xbar_op_pkg::BANK_SEL_BIT-1:0] bank_word_o,
  output logic [xbar_cfg_pkg::DATA_W-1:0]      bank_wdata_o
);

  logic                            full_q;
  logic [xbar_cfg_pkg::ID_W-1:0]   id_q;
  xbar_op_pkg::op_e                op_q;
  logic [xbar_cfg_pkg::ADDR_W-1:0] addr_q;
  logic [xbar_cfg_pkg::DATA_W-1:0] wdata_q;
  logic                            bank_sel;
  logic                            bank_ready;
  logic                            issue;
  logic                            accept;

  // --------------------------------------------------
  // issue decision
  // --------------------------------------------------
  assign bank_sel   = addr_q[xbar_op_pkg::BANK_SEL_BIT];
  assign bank_ready = bank_sel ? bank1_ready_i : bank0_ready_i;

  // slot and bank must both take it in the same cycle
  assign issue  = full_q && alloc_ready_i && bank_ready;
  assign accept = req_valid_i && req_ready_o;

  assign req_ready_o = !full_q || issue;

  assign alloc_valid_o = full_q && bank_ready;
  assign alloc_id_o    = id_q;

  assign bank0_valid_o = full_q && alloc_ready_i && !bank_sel;
  assign bank1_valid_o = full_q && alloc_ready_i && bank_sel;
  assign bank_tag_o    = alloc_tag_i;
  assign bank_op_o     = op_q;
  assign bank_word_o   = addr_q[xbar_op_pkg::BANK_SEL_BIT-1:0];
  assign bank_wdata_o  = wdata_q;

  // --------------------------------------------------
  // request stage
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (issue) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q    <= req_id_i;
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/sparse_read_buf.sv
`timescale 1ns/1ps
`default_nettype none

module sparse_read_buf (
  input  wire                               clk_i,
  input  wire                               rst_i,
  input  wire                               alloc_valid_i,
  output logic                              alloc_ready_o,
  output logic [xbar_cfg_pkg::TAG_W-1:0]    alloc_tag_o,
  input  wire [xbar_cfg_pkg::ID_W-1:0]      alloc_id_i,
  input  wire                               rel_valid_i,
  input  wire [xbar_cfg_pkg::TAG_W-1:0]     rel_tag_i,
  output logic [xbar_cfg_pkg::ID_W-1:0]     rel_id_o,
  output logic [xbar_cfg_pkg::SLOTS-1:0]    slot_valid_o,
  output logic [xbar_cfg_pkg::TAG_W-1:0]    bottom_ptr_o
);

  localparam int SLOTS = xbar_cfg_pkg::SLOTS;
  localparam int TAG_W = xbar_cfg_pkg::TAG_W;
  localparam int ID_W  = xbar_cfg_pkg::ID_W;

  logic [TAG_W-1:0]   wr_ptr_q;
  logic [TAG_W-1:0]   bot_q;
  logic [TAG_W-1:0]   bot_d;
  logic               push;
  wire  [SLOTS-1:0]   slot_valid;
  wire  [ID_W-1:0]    slot_id [SLOTS];
  logic [2*SLOTS-1:0] rot_full;
  logic [SLOTS-1:0]   rot_valid;
  logic [TAG_W-1:0]   skip;
  logic               found;

  // --------------------------------------------------
  // write pointer, in-order allocation
  // --------------------------------------------------
  assign alloc_ready_o = !slot_valid[wr_ptr_q];
  assign alloc_tag_o   = wr_ptr_q;
  assign push          = alloc_valid_i && alloc_ready_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (push) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // slot entries
  // --------------------------------------------------
  for (genvar k = 0; k < SLOTS; k++) begin : g_slot
    logic            valid_q;
    logic [ID_W-1:0] id_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        valid_q <= 1'b0;
      end else if (push && wr_ptr_q == TAG_W'(k)) begin
        valid_q <= 1'b1;
      end else if (rel_valid_i && rel_tag_i == TAG_W'(k)) begin
        valid_q <= 1'b0;
      end
    end

    // caller id kept for the response
    always_ff @(posedge clk_i) begin
      if (push && wr_ptr_q == TAG_W'(k)) begin
        id_q <= alloc_id_i;
      end
    end

    assign slot_valid[k] = valid_q;
    assign slot_id[k]    = id_q;
  end

  assign rel_id_o     = slot_id[rel_tag_i];
  assign slot_valid_o = slot_valid;

  // --------------------------------------------------
  // bottom pointer
  // --------------------------------------------------
  // rotate so the current bottom lands on bit 0
  assign rot_full  = {slot_valid, slot_valid} >> bot_q;
  assign rot_valid = rot_full[SLOTS-1:0];

  always_comb begin
    skip  = '0;
    found = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      if (!found && rot_valid[i]) begin
        skip  = TAG_W'(i);
        found = 1'b1;
      end
    end
  end

  // empty map parks the bottom on the write pointer
  assign bot_d = found ? bot_q + skip : wr_ptr_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      bot_q <= '0;
    end else begin
      bot_q <= bot_d;
    end
  end

  assign bottom_ptr_o = bot_q;

endmodule

`default_nettype wire

//--- logic/bank_target.sv
`timescale 1ns/1ps
`default_nettype none

module bank_target #(
  parameter int LAT     = 1,
  parameter int WORDS   = 16,
  parameter int BANK_ID = 0
) (
  input  wire                               clk_i,
  input  wire                               rst_i,
  input  wire                               req_valid_i,
  output logic                              req_ready_o,
  input  wire [xbar_cfg_pkg::TAG_W-1:0]     req_tag_i,
  input  wire xbar_op_pkg::op_e             req_op_i,
  input  wire [$clog2(WORDS)-1:0]           req_word_i,
  input  wire [xbar_cfg_pkg::DATA_W-1:0]    req_wdata_i,
  output logic                              rsp_valid_o,
  input  wire                               rsp_ready_i,
  output logic [xbar_cfg_pkg::TAG_W-1:0]    rsp_tag_o,
  output xbar_op_pkg::op_e                  rsp_op_o,
  output logic [xbar_cfg_pkg::DATA_W-1:0]   rsp_data_o
);

  localparam int DATA_W = xbar_cfg_pkg::DATA_W;
  localparam int TAG_W  = xbar_cfg_pkg::TAG_W;

  logic [DATA_W-1:0] mem_q [WORDS];
  logic [LAT-1:0]    pv_q;
  logic [TAG_W-1:0]  ptag_q [LAT];
  xbar_op_pkg::op_e  pop_q [LAT];
  logic [DATA_W-1:0] pdata_q [LAT];
  logic              advance;
  logic              issue;
  logic [DATA_W-1:0] issue_data;

  // whole pipe moves when the tail is empty or taken
  assign advance     = !pv_q[LAT-1] || rsp_ready_i;
  assign req_ready_o = advance;
  assign issue       = req_valid_i && advance;

  // write acks echo the data
  assign issue_data = (req_op_i == xbar_op_pkg::OP_WRITE) ? req_wdata_i : mem_q[req_word_i];

  // --------------------------------------------------
  // word storage
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int w = 0; w < WORDS; w++) begin
        mem_q[w] <= DATA_W'(w + WORDS * BANK_ID);
      end
    end else if (issue && req_op_i == xbar_op_pkg::OP_WRITE) begin
      mem_q[req_word_i] <= req_wdata_i;
    end
  end

  // --------------------------------------------------
  // fixed-latency pipeline
  // --------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pv_q <= '0;
    end else if (advance) begin
      pv_q[0] <= issue;
      for (int k = 1; k < LAT; k++) begin
        pv_q[k] <= pv_q[k-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      ptag_q[0]  <= req_tag_i;
      pop_q[0]   <= req_op_i;
      pdata_q[0] <= issue_data;
      for (int k = 1; k < LAT; k++) begin
        ptag_q[k]  <= ptag_q[k-1];
        pop_q[k]   <= pop_q[k-1];
        pdata_q[k] <= pdata_q[k-1];
      end
    end
  end

  assign rsp_valid_o = pv_q[LAT-1];
  assign rsp_tag_o   = ptag_q[LAT-1];
  assign rsp_op_o    = pop_q[LAT-1];
  assign rsp_data_o  = pdata_q[LAT-1];

endmodule

`default_nettype wire

//--- logic/rsp_egress.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_egress (
  input  wire                               clk_i,
  input  wire                               rst_i,
  input  wire                               b0_valid_i,
  output logic                              b0_ready_o,
  input  wire [xbar_cfg_pkg::TAG_W-1:0]     b0_tag_i,
  input  wire xbar_op_pkg::op_e             b0_op_i,
  input  wire [xbar_cfg_pkg::DATA_W-1:0]    b0_data_i,
  input  wire                               b1_valid_i,
  output logic                              b1_ready_o,
  input  wire [xbar_cfg_pkg::TAG_W-1:0]     b1_tag_i,
  input  wire xbar_op_pkg::op_e             b1_op_i,
  input  wire [xbar_cfg_pkg::DATA_W-1:0]    b1_data_i,
  output logic                              rsp_valid_o,
  input  wire                               rsp_ready_i,
  output logic [xbar_cfg_pkg::ID_W-1:0]     rsp_id_o,
  output xbar_op_pkg::op_e                  rsp_op_o,
  output logic [xbar_cfg_pkg::DATA_W-1:0]   rsp_data_o,
  output logic                              rel_valid_o,
  output logic [xbar_cfg_pkg::TAG_W-1:0]    rel_tag_o,
  input  wire [xbar_cfg_pkg::ID_W-1:0]      rel_id_i
);

  logic last_q;
  logic hold_q;
  logic hold_sel_q;
  logic arb_pick1;
  logic pick1;
  logic xfer;

  // --------------------------------------------------
  // arbitration
  // --------------------------------------------------
  // last winner drops to low priority
  assign arb_pick1 = b1_valid_i && (!b0_valid_i || !last_q);

  // keep the same bank on the output while stalled
  assign pick1 = hold_q ? hold_sel_q : arb_pick1;

  assign rsp_valid_o = b0_valid_i || b1_valid_i;
  assign xfer        = rsp_valid_o && rsp_ready_i;

  assign b0_ready_o = rsp_ready_i && !pick1;
  assign b1_ready_o = rsp_ready_i && pick1;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      last_q     <= 1'b0;
      hold_q     <= 1'b0;
      hold_sel_q <= 1'b0;
    end else begin
      hold_q     <= rsp_valid_o && !rsp_ready_i;
      hold_sel_q <= pick1;
      if (xfer) begin
        last_q <= pick1;
      end
    end
  end

  // --------------------------------------------------
  // response and slot release
  // --------------------------------------------------
  assign rsp_op_o   = pick1 ? b1_op_i : b0_op_i;
  assign rsp_data_o = pick1 ? b1_data_i : b0_data_i;
  assign rel_tag_o  = pick1 ? b1_tag_i : b0_tag_i;

  // id comes back from the slot buffer
  assign rsp_id_o    = rel_id_i;
  assign rel_valid_o = xfer;

endmodule

`default_nettype wire

//--- logic/xbar_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_read_port #(
  parameter int BANK0_LAT = 1,
  parameter int BANK1_LAT = 3
) (
  input  wire                               clk_i,
  input  wire                               rst_i,
  input  wire                               req_valid_i,
  output logic                              req_ready_o,
  input  wire [xbar_cfg_pkg::ID_W-1:0]      req_id_i,
  input  wire xbar_op_pkg::op_e             req_op_i,
  input  wire [xbar_cfg_pkg::ADDR_W-1:0]    req_addr_i,
  input  wire [xbar_cfg_pkg::DATA_W-1:0]    req_wdata_i,
  output logic                              rsp_valid_o,
  input  wire                               rsp_ready_i,
  output logic [xbar_cfg_pkg::ID_W-1:0]     rsp_id_o,
  output xbar_op_pkg::op_e                  rsp_op_o,
  output logic [xbar_cfg_pkg::DATA_W-1:0]   rsp_data_o,
  output logic [xbar_cfg_pkg::SLOTS-1:0]    slot_valid_o,
  output logic [xbar_cfg_pkg::TAG_W-1:0]    bottom_ptr_o
);

  localparam int WORD_W     = xbar_op_pkg::BANK_SEL_BIT;
  localparam int BANK_WORDS = 1 << WORD_W;

  // ingress and slot buffer
  logic                              alloc_valid;
  logic                              alloc_ready;
  logic [xbar_cfg_pkg::TAG_W-1:0]    alloc_tag;
  logic [xbar_cfg_pkg::ID_W-1:0]     alloc_id;
  logic                              rel_valid;
  logic [xbar_cfg_pkg::TAG_W-1:0]    rel_tag;
  logic [xbar_cfg_pkg::ID_W-1:0]     rel_id;

  // shared request lines toward both banks
  logic                              b0_req_valid;
  logic                              b0_req_ready;
  logic                              b1_req_valid;
  logic                              b1_req_ready;
  logic [xbar_cfg_pkg::TAG_W-1:0]    bank_tag;
  xbar_op_pkg::op_e                  bank_op;
  logic [WORD_W-1:0]                 bank_word;
  logic [xbar_cfg_pkg::DATA_W-1:0]   bank_wdata;

  // bank responses
  logic                              b0_rsp_valid;
  logic                              b0_rsp_ready;
  logic [xbar_cfg_pkg::TAG_W-1:0]    b0_rsp_tag;
  xbar_op_pkg::op_e                  b0_rsp_op;
  logic [xbar_cfg_pkg::DATA_W-1:0]   b0_rsp_data;
  logic                              b1_rsp_valid;
  logic                              b1_rsp_ready;
  logic [xbar_cfg_pkg::TAG_W-1:0]    b1_rsp_tag;
  xbar_op_pkg::op_e                  b1_rsp_op;
  logic [xbar_cfg_pkg::DATA_W-1:0]   b1_rsp_data;

  req_ingress req_ingress_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_id_i      (req_id_i),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .alloc_ready_i (alloc_ready),
    .alloc_tag_i   (alloc_tag),
    .bank0_ready_i (b0_req_ready),
    .bank1_ready_i (b1_req_ready),
    .alloc_valid_o (alloc_valid),
    .alloc_id_o    (alloc_id),
    .bank0_valid_o (b0_req_valid),
    .bank1_valid_o (b1_req_valid),
    .bank_tag_o    (bank_tag),
    .bank_op_o     (bank_op),
    .bank_word_o   (bank_word),
    .bank_wdata_o  (bank_wdata)
  );

  sparse_read_buf sparse_read_buf_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .alloc_valid_i (alloc_valid),
    .alloc_ready_o (alloc_ready),
    .alloc_tag_o   (alloc_tag),
    .alloc_id_i    (alloc_id),
    .rel_valid_i   (rel_valid),
    .rel_tag_i     (rel_tag),
    .rel_id_o      (rel_id),
    .slot_valid_o  (slot_valid_o),
    .bottom_ptr_o  (bottom_ptr_o)
  );

  bank_target #(
    .LAT     (BANK0_LAT),
    .WORDS   (BANK_WORDS),
    .BANK_ID (0)
  ) bank0_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (b0_req_valid),
    .req_ready_o (b0_req_ready),
    .req_tag_i   (bank_tag),
    .req_op_i    (bank_op),
    .req_word_i  (bank_word),
    .req_wdata_i (bank_wdata),
    .rsp_valid_o (b0_rsp_valid),
    .rsp_ready_i (b0_rsp_ready),
    .rsp_tag_o   (b0_rsp_tag),
    .rsp_op_o    (b0_rsp_op),
    .rsp_data_o  (b0_rsp_data)
  );

  bank_target #(
    .LAT     (BANK1_LAT),
    .WORDS   (BANK_WORDS),
    .BANK_ID (1)
  ) bank1_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (b1_req_valid),
    .req_ready_o (b1_req_ready),
    .req_tag_i   (bank_tag),
    .req_op_i    (bank_op),
    .req_word_i  (bank_word),
    .req_wdata_i (bank_wdata),
    .rsp_valid_o (b1_rsp_valid),
    .rsp_ready_i (b1_rsp_ready),
    .rsp_tag_o   (b1_rsp_tag),
    .rsp_op_o    (b1_rsp_op),
    .rsp_data_o  (b1_rsp_data)
  );

  rsp_egress rsp_egress_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .b0_valid_i  (b0_rsp_valid),
    .b0_ready_o  (b0_rsp_ready),
    .b0_tag_i    (b0_rsp_tag),
    .b0_op_i     (b0_rsp_op),
    .b0_data_i   (b0_rsp_data),
    .b1_valid_i  (b1_rsp_valid),
    .b1_ready_o  (b1_rsp_ready),
    .b1_tag_i    (b1_rsp_tag),
    .b1_op_i     (b1_rsp_op),
    .b1_data_i   (b1_rsp_data),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_id_o    (rsp_id_o),
    .rsp_op_o    (rsp_op_o),
    .rsp_data_o  (rsp_data_o),
    .rel_valid_o (rel_valid),
    .rel_tag_o   (rel_tag),
    .rel_id_i    (rel_id)
  );

endmodule

`default_nettype wire

//--- tests/xbar_read_port_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_read_port_tb;

  localparam int NUM_REQ  = 80;
  localparam int LIMIT_NS = (200 + 20 * NUM_REQ) * 10;

  logic                                  clk_i;
  logic                                  rst_i;
  logic                                  req_valid_i;
  logic                                  req_ready_o;
  logic [xbar_cfg_pkg::ID_W-1:0]         req_id_i;
  xbar_op_pkg::op_e                      req_op_i;
  logic [xbar_cfg_pkg::ADDR_W-1:0]       req_addr_i;
  logic [xbar_cfg_pkg::DATA_W-1:0]       req_wdata_i;
  logic                                  rsp_valid_o;
  logic                                  rsp_ready_i;
  logic [xbar_cfg_pkg::ID_W-1:0]         rsp_id_o;
  xbar_op_pkg::op_e                      rsp_op_o;
  logic [xbar_cfg_pkg::DATA_W-1:0]       rsp_data_o;
  logic [xbar_cfg_pkg::SLOTS-1:0]        slot_valid_o;
  logic [xbar_cfg_pkg::TAG_W-1:0]        bottom_ptr_o;

  // reference memory by address and scoreboard by id
  logic [7:0]  ref_mem [32];
  logic        busy    [16];
  logic        live    [16];
  logic        exp_op  [16];
  logic [7:0]  exp_data [16];
  logic [2:0]  slot_of [16];
  logic [3:0]  last_id;
  int          accept_cnt;
  int          out_cnt;
  int          error_cnt;
  int          ready_mode;
  logic [31:0] stim_seed;
  logic [31:0] ready_seed;
  logic        have_pred;
  logic [2:0]  pred_bot;

  xbar_read_port xbar_read_port_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_id_i     (req_id_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_id_o     (rsp_id_o),
    .rsp_op_o     (rsp_op_o),
    .rsp_data_o   (rsp_data_o),
    .slot_valid_o (slot_valid_o),
    .bottom_ptr_o (bottom_ptr_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // a write echoes its data, a read returns the current word
  function automatic logic [7:0] expected_data(input logic op, input logic [4:0] addr,
                                               input logic [7:0] wdata);
    return op ? wdata : ref_mem[addr];
  endfunction

  // oldest valid slot counting up from the bottom with wrap
  function automatic logic [2:0] oldest_slot(input logic [7:0] sv, input logic [2:0] bot);
    logic [2:0] idx;
    logic [2:0] res;
    logic       hit;
    res = bot;
    hit = 1'b0;
    for (int i = 0; i < 8; i++) begin
      idx = bot + 3'(i);
      if (!hit && sv[idx]) begin
        res = idx;
        hit = 1'b1;
      end
    end
    return res;
  endfunction

  task automatic fail_now(input string msg);
    error_cnt++;
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(input string name, input int exp_v, input int act_v);
    if (exp_v != act_v) begin
      $display("Fail %s: expected %0h, actual %0h", name, exp_v, act_v);
      fail_now("value mismatch");
    end
  endtask

  // present a request and wait up to max_cyc edges for acceptance
  task automatic try_send(input logic op, input logic [4:0] addr, input logic [7:0] wdata,
                          input int max_cyc, output logic ok);
    logic [3:0] id;
    id = 4'(stim_seed[19:16]);
    while (busy[id]) begin
      id = id + 4'd1;
    end
    busy[id] = 1'b1;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_id_i    = id;
    req_op_i    = xbar_op_pkg::op_e'(op);
    req_addr_i  = addr;
    req_wdata_i = wdata;
    wait_accept(max_cyc, ok);
  endtask

  task automatic wait_accept(input int max_cyc, output logic ok);
    ok = 1'b0;
    for (int c = 0; c < max_cyc && !ok; c++) begin
      @(posedge clk_i);
      ok = req_ready_o;
    end
    if (ok) begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
    end
  endtask

  task automatic send(input logic op, input logic [4:0] addr, input logic [7:0] wdata);
    logic ok;
    try_send(op, addr, wdata, 1000, ok);
    if (!ok) begin
      fail_now("request was not accepted within 1000 cycles");
    end
  endtask

  // --------------------------------------------------
  // monitor and scoreboard
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      if (!live[rsp_id_o]) begin
        fail_now("response carries an id that is not outstanding");
      end
      check_val("response op", int'(exp_op[rsp_id_o]), int'(rsp_op_o));
      check_val("response data", int'(exp_data[rsp_id_o]), int'(rsp_data_o));
      live[rsp_id_o] = 1'b0;
      busy[rsp_id_o] = 1'b0;
      out_cnt--;
    end
    if (!rst_i && req_valid_i && req_ready_o) begin
      exp_op[req_id_i]   = req_op_i;
      exp_data[req_id_i] = expected_data(req_op_i, req_addr_i, req_wdata_i);
      if (req_op_i == xbar_op_pkg::OP_WRITE) begin
        ref_mem[req_addr_i] = req_wdata_i;
      end
      slot_of[req_id_i] = 3'(accept_cnt);
      live[req_id_i]    = 1'b1;
      last_id           = req_id_i;
      accept_cnt++;
      out_cnt++;
    end
  end

  // status outputs against the outstanding set and the bottom rule
  always @(negedge clk_i) begin
    logic owned;
    if (!rst_i) begin
      for (int k = 0; k < 8; k++) begin
        owned = 1'b0;
        for (int i = 0; i < 16; i++) begin
          if (live[i] && slot_of[i] == 3'(k)) begin
            owned = 1'b1;
          end
        end
        if (slot_valid_o[k] && !owned) begin
          fail_now($sformatf("slot %0d is valid but no outstanding request owns it", k));
        end
      end
      // only the newest request may still sit in the ingress stage
      for (int i = 0; i < 16; i++) begin
        if (live[i] && !slot_valid_o[slot_of[i]] && 4'(i) != last_id) begin
          fail_now($sformatf("slot %0d is not valid while its request is outstanding",
                             slot_of[i]));
        end
      end
      if (have_pred) begin
        check_val("bottom pointer", int'(pred_bot), int'(bottom_ptr_o));
      end
      have_pred = |slot_valid_o;
      pred_bot  = oldest_slot(slot_valid_o, bottom_ptr_o);
    end
  end

  always @(negedge clk_i) begin
    ready_seed = lcg(ready_seed);
    case (ready_mode)
      1:       rsp_ready_i = ready_seed[20] | ready_seed[22];
      2:       rsp_ready_i = 1'b0;
      default: rsp_ready_i = 1'b1;
    endcase
  end

  initial begin
    #(LIMIT_NS);
    fail_now("timeout: the test did not finish in time");
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    logic ok;
    int   base;
    clk_i = 1'b0;
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_id_i    = '0;
    req_op_i    = xbar_op_pkg::OP_READ;
    req_addr_i  = '0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b1;
    accept_cnt = 0;
    out_cnt    = 0;
    error_cnt  = 0;
    ready_mode = 0;
    have_pred  = 1'b0;
    pred_bot   = '0;
    last_id    = '0;
    stim_seed  = 32'd44148;
    ready_seed = lcg(32'd44148);
    for (int a = 0; a < 32; a++) begin
      ref_mem[a] = 8'(a);
    end
    for (int i = 0; i < 16; i++) begin
      busy[i] = 1'b0;
      live[i] = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // reads of the reset image, then write and read back
    send(1'b0, 5'd3, 8'h00);
    send(1'b0, 5'd20, 8'h00);
    send(1'b1, 5'd5, 8'hA5);
    send(1'b0, 5'd5, 8'h00);
    send(1'b1, 5'd22, 8'h3C);
    send(1'b0, 5'd22, 8'h00);
    wait (out_cnt == 0);

    // random traffic over both banks
    ready_mode = 1;
    for (int n = 0; n < 60; n++) begin
      stim_seed = lcg(stim_seed);
      send(stim_seed[24], 5'(stim_seed[29:25]), stim_seed[23:16]);
    end
    ready_mode = 0;
    wait (out_cnt == 0);

    // back-pressure until the port stops accepting
    ready_mode = 2;
    repeat (2) @(negedge clk_i);
    base = accept_cnt;
    ok   = 1'b1;
    for (int n = 0; n < 12 && ok; n++) begin
      stim_seed = lcg(stim_seed);
      try_send(1'b0, 5'(stim_seed[29:25]), 8'h00, 20, ok);
    end
    if (accept_cnt - base > 9) begin
      fail_now("more than 9 requests accepted while responses were blocked");
    end
    if (ok) begin
      fail_now("request port never stopped accepting under back-pressure");
    end
    ready_mode = 0;
    wait_accept(1000, ok);
    if (!ok) begin
      fail_now("pending request was not accepted after responses were released");
    end
    wait (out_cnt == 0);

    // idle port parks the bottom on the write pointer
    repeat (4) @(negedge clk_i);
    check_val("idle slot map", 0, int'(slot_valid_o));
    check_val("idle bottom pointer", accept_cnt % 8, int'(bottom_ptr_o));

    if (error_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "errors were found");
    end
  end

endmodule

`default_nettype wire

//--- xbar_read_port.f
logic/xbar_cfg_pkg.sv
logic/xbar_op_pkg.sv
logic/req_ingress.sv
logic/sparse_read_buf.sv
logic/bank_target.sv
logic/rsp_egress.sv
logic/xbar_read_port.sv
tests/xbar_read_port_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module xbar_read_port_tb \
  -f xbar_read_port.f -o sim_xbar_read_port \
  && ./obj_dir/sim_xbar_read_port | tee /dev/stderr | grep -q "STATUS: PASS" \
  && exit 0 \
  || exit 1
